// File: source/exec_pkg.sv
package exec_pkg;

	localparam int LANES = 4;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] strand_t;
	typedef logic [LANES-1:0] lane_mask_t;
	typedef logic [LANES*32-1:0] vector_t;

	// One bit per execute sub-stage, 0 is the issue cycle
	typedef logic [3:0] squash_t;

	// Scalar register 31 reads as the program counter
	localparam reg_idx_t REG_PC = 5'd31;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SHL,
		OP_SHR,
		OP_EQ,
		OP_MUL
	} alu_op_e;

	typedef enum logic [1:0] {
		OP2_SCALAR2,
		OP2_VECTOR2,
		OP2_IMMEDIATE
	} op2_src_e;

	typedef enum logic [2:0] {
		MASK_SCALAR1,
		MASK_SCALAR1_INV,
		MASK_SCALAR2,
		MASK_SCALAR2_INV,
		MASK_ALL_ONES
	} mask_src_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ZERO,
		BR_NOT_ZERO,
		BR_ALL,
		BR_NOT_ALL,
		BR_ALWAYS
	} branch_e;

	// Instruction as it arrives from the issuer
	typedef struct packed {
		logic valid;
		strand_t strand;
		word_t pc;
		alu_op_e op;
		branch_e branch;
		word_t branch_offset;
		logic predicted_taken;
		logic op1_is_vector;
		op2_src_e op2_src;
		word_t immediate;
		mask_src_e mask_src;
		reg_idx_t sel_s1;
		reg_idx_t sel_s2;
		reg_idx_t sel_v1;
		reg_idx_t sel_v2;
		reg_idx_t dest;
		logic scalar_wb;
		logic vector_wb;
	} issue_t;

	typedef struct packed {
		word_t scalar1;
		word_t scalar2;
		vector_t vector1;
		vector_t vector2;
	} regs_t;

	// Result bundle, also the format of bypass sources
	typedef struct packed {
		logic valid;
		strand_t strand;
		word_t pc;
		reg_idx_t dest;
		logic scalar_wb;
		logic vector_wb;
		lane_mask_t mask;
		vector_t value;
	} writeback_t;

	typedef struct packed {
		vector_t op1;
		vector_t op2;
		lane_mask_t mask;
	} operands_t;

endpackage

// File: source/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass(
	input exec_pkg::issue_t issue_i,
	input exec_pkg::regs_t regs_i,
	input exec_pkg::writeback_t ex_i,
	input exec_pkg::writeback_t commit_i,
	output exec_pkg::operands_t operands_o
);
	import exec_pkg::*;

	word_t scalar1;
	word_t scalar2;
	vector_t vector1;
	vector_t vector2;

	// PC first, then the newest producer
	function automatic word_t scalar_read(reg_idx_t sel, word_t rf_value);
		if (sel == REG_PC)
			return issue_i.pc;
		else if (ex_i.valid && ex_i.scalar_wb && ex_i.dest == sel)
			return ex_i.value[31:0];
		else if (commit_i.valid && commit_i.scalar_wb && commit_i.dest == sel)
			return commit_i.value[31:0];
		else
			return rf_value;
	endfunction

	// Lane by lane, only lanes in the producer's mask are replaced
	function automatic vector_t vector_read(reg_idx_t sel, vector_t rf_value);
		vector_t value;
		logic ex_hit;
		logic commit_hit;
		value = rf_value;
		ex_hit = ex_i.valid && ex_i.vector_wb && ex_i.dest == sel;
		commit_hit = commit_i.valid && commit_i.vector_wb && commit_i.dest == sel;
		for (int lane = 0; lane < LANES; lane++)
		begin
			if (ex_hit && ex_i.mask[lane])
				value[lane*32 +: 32] = ex_i.value[lane*32 +: 32];
			else if (commit_hit && commit_i.mask[lane])
				value[lane*32 +: 32] = commit_i.value[lane*32 +: 32];
		end
		return value;
	endfunction

	always_comb
	begin
		scalar1 = scalar_read(issue_i.sel_s1, regs_i.scalar1);
		scalar2 = scalar_read(issue_i.sel_s2, regs_i.scalar2);
		vector1 = vector_read(issue_i.sel_v1, regs_i.vector1);
		vector2 = vector_read(issue_i.sel_v2, regs_i.vector2);

		// Scalars are broadcast to every lane
		operands_o.op1 = issue_i.op1_is_vector ? vector1 : {LANES{scalar1}};

		case (issue_i.op2_src)
			OP2_SCALAR2: operands_o.op2 = {LANES{scalar2}};
			OP2_VECTOR2: operands_o.op2 = vector2;
			OP2_IMMEDIATE: operands_o.op2 = {LANES{issue_i.immediate}};
			default: operands_o.op2 = '0;
		endcase

		case (issue_i.mask_src)
			MASK_SCALAR1: operands_o.mask = scalar1[LANES-1:0];
			MASK_SCALAR1_INV: operands_o.mask = ~scalar1[LANES-1:0];
			MASK_SCALAR2: operands_o.mask = scalar2[LANES-1:0];
			MASK_SCALAR2_INV: operands_o.mask = ~scalar2[LANES-1:0];
			default: operands_o.mask = '1;
		endcase
	end

endmodule

// File: source/lane_alu.sv
`timescale 1ns/1ps

module lane_alu(
	input exec_pkg::alu_op_e op_i,
	input exec_pkg::operands_t operands_i,
	output exec_pkg::vector_t result_o
);
	import exec_pkg::*;

	vector_t lane_result;
	lane_mask_t compare;

	always_comb
	begin
		word_t a;
		word_t b;
		word_t r;
		for (int lane = 0; lane < LANES; lane++)
		begin
			a = operands_i.op1[lane*32 +: 32];
			b = operands_i.op2[lane*32 +: 32];
			case (op_i)
				OP_ADD: r = a + b;
				OP_SUB: r = a - b;
				OP_AND: r = a & b;
				OP_OR: r = a | b;
				OP_XOR: r = a ^ b;
				OP_SHL: r = a << b[4:0];
				OP_SHR: r = a >> b[4:0];
				OP_EQ: r = {31'd0, a == b};
				// Multiply goes down the long path
				default: r = '0;
			endcase
			lane_result[lane*32 +: 32] = r;
			compare[lane] = r[0];
		end
	end

	// Compares collapse to one bit per lane in the bottom of lane 0
	always_comb
	begin
		if (op_i == OP_EQ)
		begin
			result_o = '0;
			result_o[LANES-1:0] = compare;
		end
		else
			result_o = lane_result;
	end

endmodule

// File: source/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve(
	input exec_pkg::issue_t issue_i,
	input exec_pkg::vector_t op1_i,
	input exec_pkg::word_t alu_result_i,
	output logic rollback_o,
	output exec_pkg::word_t rollback_pc_o
);
	import exec_pkg::*;

	logic taken;
	word_t target;
	logic all_set;

	assign all_set = op1_i[LANES-1:0] == {LANES{1'b1}};

	always_comb
	begin
		target = issue_i.pc + issue_i.branch_offset;
		if (issue_i.op != OP_MUL && issue_i.scalar_wb && issue_i.dest == REG_PC)
		begin
			// Single-cycle arithmetic into PC acts as a jump
			taken = 1'b1;
			target = alu_result_i;
		end
		else
		begin
			case (issue_i.branch)
				BR_ZERO: taken = op1_i[31:0] == 32'd0;
				BR_NOT_ZERO: taken = op1_i[31:0] != 32'd0;
				BR_ALL: taken = all_set;
				BR_NOT_ALL: taken = !all_set;
				BR_ALWAYS: taken = 1'b1;
				default: taken = 1'b0;
			endcase
		end
	end

	// Prediction was wrong in either direction
	assign rollback_o = issue_i.valid && (taken != issue_i.predicted_taken);
	assign rollback_pc_o = taken ? target : issue_i.pc + 32'd4;

endmodule

// File: source/long_latency_pipe.sv
`timescale 1ns/1ps

module long_latency_pipe #(
	parameter int MUL_STAGES = 3
)(
	input logic clk,
	input logic reset,
	input exec_pkg::issue_t issue_i,
	input exec_pkg::operands_t operands_i,
	input exec_pkg::squash_t squash_i,
	output exec_pkg::writeback_t tail_o
);
	import exec_pkg::*;

	writeback_t stage_q [1:MUL_STAGES];
	writeback_t entry;
	vector_t product;
	logic [MUL_STAGES-1:0] kill;

	// Rollback controller only sees sub-stages 0 to 2 here, the tail is killed at the merge
	for (genvar k = 0; k < MUL_STAGES; k++)
	begin : g_kill
		if (k < 3)
			assign kill[k] = squash_i[k];
		else
			assign kill[k] = 1'b0;
	end

	// Low 32 bits of each lane product
	always_comb
	begin
		for (int lane = 0; lane < LANES; lane++)
			product[lane*32 +: 32] = operands_i.op1[lane*32 +: 32]
				* operands_i.op2[lane*32 +: 32];
	end

	always_comb
	begin
		entry = '0;
		if (issue_i.valid && issue_i.op == OP_MUL && !kill[0])
		begin
			entry.valid = 1'b1;
			entry.strand = issue_i.strand;
			entry.pc = issue_i.pc;
			entry.dest = issue_i.dest;
			entry.scalar_wb = issue_i.scalar_wb;
			entry.vector_wb = issue_i.vector_wb;
			entry.mask = operands_i.mask;
			entry.value = product;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int k = 1; k <= MUL_STAGES; k++)
				stage_q[k] <= '0;
		end
		else
		begin
			stage_q[1] <= entry;
			for (int k = 2; k <= MUL_STAGES; k++)
			begin
				if (kill[k-1])
					stage_q[k] <= '0;
				else
					stage_q[k] <= stage_q[k-1];
			end
		end
	end

	assign tail_o = stage_q[MUL_STAGES];

endmodule

// File: source/result_merge.sv
`timescale 1ns/1ps

module result_merge(
	input logic clk,
	input logic reset,
	input exec_pkg::writeback_t short_i,
	input exec_pkg::writeback_t tail_i,
	input exec_pkg::squash_t squash_i,
	output exec_pkg::writeback_t ex_o
);
	import exec_pkg::*;

	writeback_t merge_nxt;

	// Both paths may land in one cycle; the issuer keeps them apart
	always_comb
	begin
		if (tail_i.valid && !squash_i[3])
			merge_nxt = tail_i;
		else if (short_i.valid)
			merge_nxt = short_i;
		else
			merge_nxt = '0;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ex_o <= '0;
		else
			ex_o <= merge_nxt;
	end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
	parameter int MUL_STAGES = 3
)(
	input logic clk,
	input logic reset,
	input exec_pkg::issue_t issue_i,
	input exec_pkg::regs_t regs_i,
	input exec_pkg::writeback_t commit_i,
	input exec_pkg::squash_t squash_i,
	output exec_pkg::writeback_t ex_o,
	output logic rollback_o,
	output exec_pkg::word_t rollback_pc_o
);
	import exec_pkg::*;

	operands_t operands;
	vector_t alu_result;
	writeback_t short_entry;
	writeback_t tail;
	issue_t issue_live;

	// Issue with a squash at sub-stage 0 folded into valid
	always_comb
	begin
		issue_live = issue_i;
		issue_live.valid = issue_i.valid && !squash_i[0];
	end

	operand_bypass u_operand_bypass(
		.issue_i(issue_i),
		.regs_i(regs_i),
		.ex_i(ex_o),
		.commit_i(commit_i),
		.operands_o(operands)
	);

	lane_alu u_lane_alu(
		.op_i(issue_i.op),
		.operands_i(operands),
		.result_o(alu_result)
	);

	branch_resolve u_branch_resolve(
		.issue_i(issue_live),
		.op1_i(operands.op1),
		.alu_result_i(alu_result[31:0]),
		.rollback_o(rollback_o),
		.rollback_pc_o(rollback_pc_o)
	);

	long_latency_pipe #(
		.MUL_STAGES(MUL_STAGES)
	) u_long_latency_pipe(
		.clk(clk),
		.reset(reset),
		.issue_i(issue_i),
		.operands_i(operands),
		.squash_i(squash_i),
		.tail_o(tail)
	);

	// Single-cycle candidate for the output register
	always_comb
	begin
		short_entry.valid = issue_live.valid && issue_i.op != OP_MUL;
		short_entry.strand = issue_i.strand;
		short_entry.pc = issue_i.pc;
		short_entry.dest = issue_i.dest;
		short_entry.scalar_wb = issue_i.scalar_wb;
		short_entry.vector_wb = issue_i.vector_wb;
		short_entry.mask = operands.mask;
		short_entry.value = alu_result;
	end

	result_merge u_result_merge(
		.clk(clk),
		.reset(reset),
		.short_i(short_entry),
		.tail_i(tail),
		.squash_i(squash_i),
		.ex_o(ex_o)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock(
	output logic clk_o
);

	// 20 ns period
	initial
	begin
		clk_o = 1'b0;
		forever
			#10 clk_o = ~clk_o;
	end

endmodule

// File: tests/execute_stage_chk.sv
`timescale 1ns/1ps

module execute_stage_chk(
	input logic clk,
	input logic reset,
	input exec_pkg::issue_t issue_i,
	input exec_pkg::writeback_t ex_i,
	input logic rollback_i,
	input exec_pkg::writeback_t short_i,
	input exec_pkg::writeback_t tail_i
);

	logic issue_seen;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			issue_seen <= 1'b0;
		else if (issue_i.valid)
			issue_seen <= 1'b1;
	end

	// Output register stays empty until the first issue
	quiet_until_issue: assert property (@(posedge clk) disable iff (reset)
		!issue_seen |-> !ex_i.valid)
		else $error("ex_o.valid raised before any instruction was issued");

	rollback_needs_issue: assert property (@(posedge clk) disable iff (reset)
		rollback_i |-> issue_i.valid)
		else $error("rollback raised without a valid issue");

	// Issuer must keep short ops away from a multiply leaving the tail
	no_merge_collision: assert property (@(posedge clk) disable iff (reset)
		!(tail_i.valid && short_i.valid))
		else $error("multiply tail and short result reached the merge together");

endmodule

// File: tests/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb;
	import exec_pkg::*;

	logic clk;
	logic reset;
	issue_t issue;
	regs_t regs;
	writeback_t commit;
	squash_t squash;
	writeback_t ex;
	logic rollback;
	word_t rollback_pc;

	word_t srf [32];
	vector_t vrf [32];
	writeback_t expected [int];
	squash_t squash_at [int];
	bit short_blocked [int];
	writeback_t commit_plan;
	logic exp_rollback;
	word_t exp_rollback_pc;
	int cycle = 0;
	int issued = 0;
	int stages;

	tb_clock u_tb_clock(
		.clk_o(clk)
	);

	execute_stage u_execute_stage(
		.clk(clk),
		.reset(reset),
		.issue_i(issue),
		.regs_i(regs),
		.commit_i(commit),
		.squash_i(squash),
		.ex_o(ex),
		.rollback_o(rollback),
		.rollback_pc_o(rollback_pc)
	);

	bind execute_stage execute_stage_chk u_execute_stage_chk(
		.clk(clk),
		.reset(reset),
		.issue_i(issue_i),
		.ex_i(ex_o),
		.rollback_i(rollback_o),
		.short_i(short_entry),
		.tail_i(tail)
	);

	task automatic end_with_failure(string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic check_field(string field, logic [127:0] got, logic [127:0] want);
		assert (got == want)
		else
			end_with_failure($sformatf("ERROR %s got %h expected %h", field, got, want));
	endtask

	// Register file, then commit, then ex_o, and the PC above all
	function automatic word_t model_scalar(reg_idx_t sel, word_t pc, writeback_t cur_ex,
		writeback_t cm);
		word_t v;
		v = srf[sel];
		if (cm.valid && cm.scalar_wb && cm.dest == sel)
			v = cm.value[31:0];
		if (cur_ex.valid && cur_ex.scalar_wb && cur_ex.dest == sel)
			v = cur_ex.value[31:0];
		if (sel == REG_PC)
			v = pc;
		return v;
	endfunction

	function automatic vector_t model_vector(reg_idx_t sel, writeback_t cur_ex, writeback_t cm);
		vector_t v;
		v = vrf[sel];
		for (int l = 0; l < LANES; l++)
		begin
			if (cm.valid && cm.vector_wb && cm.dest == sel && cm.mask[l])
				v[l*32 +: 32] = cm.value[l*32 +: 32];
			if (cur_ex.valid && cur_ex.vector_wb && cur_ex.dest == sel && cur_ex.mask[l])
				v[l*32 +: 32] = cur_ex.value[l*32 +: 32];
		end
		return v;
	endfunction

	// EQ leaves one bit per lane at the bottom of lane 0
	function automatic vector_t model_alu(alu_op_e op, vector_t a, vector_t b);
		vector_t r;
		word_t x;
		word_t y;
		r = '0;
		for (int l = 0; l < LANES; l++)
		begin
			x = a[l*32 +: 32];
			y = b[l*32 +: 32];
			case (op)
				OP_ADD: r[l*32 +: 32] = x + y;
				OP_SUB: r[l*32 +: 32] = x - y;
				OP_AND: r[l*32 +: 32] = x & y;
				OP_OR: r[l*32 +: 32] = x | y;
				OP_XOR: r[l*32 +: 32] = x ^ y;
				OP_SHL: r[l*32 +: 32] = x << y[4:0];
				OP_SHR: r[l*32 +: 32] = x >> y[4:0];
				OP_EQ: r[l] = (x == y);
				default: r[l*32 +: 32] = x * y;
			endcase
		end
		return r;
	endfunction

	function automatic reg_idx_t random_sel();
		return ($urandom_range(0, 7) == 0) ? REG_PC : reg_idx_t'($urandom_range(0, 3));
	endfunction

	// Narrow register range so bypass sources hit often
	function automatic issue_t random_issue(alu_op_e op);
		issue_t ins;
		ins = '0;
		ins.valid = 1'b1;
		ins.strand = strand_t'($urandom);
		ins.pc = $urandom & 32'hffff_fffc;
		ins.op = op;
		ins.branch_offset = $urandom & 32'hffff_fffc;
		ins.op1_is_vector = 1'($urandom);
		ins.op2_src = op2_src_e'($urandom_range(0, 2));
		ins.immediate = $urandom;
		ins.mask_src = mask_src_e'($urandom_range(0, 4));
		ins.sel_s1 = random_sel();
		ins.sel_s2 = random_sel();
		ins.sel_v1 = random_sel();
		ins.sel_v2 = random_sel();
		ins.dest = reg_idx_t'($urandom_range(1, 3));
		ins.scalar_wb = 1'($urandom);
		ins.vector_wb = 1'($urandom);
		return ins;
	endfunction

	function automatic writeback_t random_commit();
		writeback_t wb;
		wb = '0;
		wb.valid = 1'($urandom);
		wb.dest = reg_idx_t'($urandom_range(1, 3));
		wb.scalar_wb = 1'($urandom);
		wb.vector_wb = 1'($urandom);
		wb.mask = lane_mask_t'($urandom);
		wb.value = {$urandom, $urandom, $urandom, $urandom};
		return wb;
	endfunction

	task automatic drive_idle();
		issue.valid = 1'b0;
		commit = '0;
		squash = squash_at.exists(cycle) ? squash_at[cycle] : '0;
		exp_rollback = 1'b0;
	endtask

	// One instruction per call, kill_stage below zero means no squash
	task automatic step(issue_t ins, int kill_stage);
		writeback_t cur_ex;
		word_t s1;
		word_t s2;
		vector_t op1;
		vector_t op2;
		lane_mask_t mask;
		vector_t res;
		logic taken;
		word_t target;
		int c;
		@(posedge clk);
		#2;
		while (ins.valid && ins.op != OP_MUL && short_blocked.exists(cycle))
		begin
			drive_idle();
			@(posedge clk);
			#2;
		end
		if (!ins.valid)
		begin
			drive_idle();
			return;
		end
		issued++;
		c = cycle + kill_stage;
		if (kill_stage >= 0)
			squash_at[c] = (squash_at.exists(c) ? squash_at[c] : '0) | squash_t'(1 << kill_stage);
		cur_ex = expected.exists(cycle) ? expected[cycle] : writeback_t'(0);
		issue = ins;
		regs.scalar1 = srf[ins.sel_s1];
		regs.scalar2 = srf[ins.sel_s2];
		regs.vector1 = vrf[ins.sel_v1];
		regs.vector2 = vrf[ins.sel_v2];
		commit = commit_plan;
		squash = squash_at.exists(cycle) ? squash_at[cycle] : '0;

		s1 = model_scalar(ins.sel_s1, ins.pc, cur_ex, commit_plan);
		s2 = model_scalar(ins.sel_s2, ins.pc, cur_ex, commit_plan);
		op1 = ins.op1_is_vector ? model_vector(ins.sel_v1, cur_ex, commit_plan) : {LANES{s1}};
		if (ins.op2_src == OP2_IMMEDIATE)
			op2 = {LANES{ins.immediate}};
		else if (ins.op2_src == OP2_VECTOR2)
			op2 = model_vector(ins.sel_v2, cur_ex, commit_plan);
		else
			op2 = {LANES{s2}};
		case (ins.mask_src)
			MASK_SCALAR1: mask = s1[LANES-1:0];
			MASK_SCALAR1_INV: mask = ~s1[LANES-1:0];
			MASK_SCALAR2: mask = s2[LANES-1:0];
			MASK_SCALAR2_INV: mask = ~s2[LANES-1:0];
			default: mask = '1;
		endcase
		res = model_alu(ins.op, op1, op2);

		target = ins.pc + ins.branch_offset;
		case (ins.branch)
			BR_ZERO: taken = op1[31:0] == 32'd0;
			BR_NOT_ZERO: taken = op1[31:0] != 32'd0;
			BR_ALL: taken = &op1[LANES-1:0];
			BR_NOT_ALL: taken = !(&op1[LANES-1:0]);
			BR_ALWAYS: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		// Arithmetic into the PC is a jump to the result
		if (ins.op != OP_MUL && ins.scalar_wb && ins.dest == REG_PC)
		begin
			taken = 1'b1;
			target = res[31:0];
		end
		exp_rollback = kill_stage != 0 && taken != ins.predicted_taken;
		exp_rollback_pc = taken ? target : ins.pc + 32'd4;

		if (ins.op == OP_MUL && kill_stage != 0)
			short_blocked[cycle + stages] = 1'b1;
		if (kill_stage < 0)
			expected[cycle + 1 + (ins.op == OP_MUL ? stages : 0)] =
				'{1'b1, ins.strand, ins.pc, ins.dest, ins.scalar_wb, ins.vector_wb, mask, res};
		commit_plan = '0;
	endtask

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle > issued * (stages + 4) + 100)
			end_with_failure($sformatf("Timeout after %0d cycles", cycle));
	end

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		writeback_t want;
		if (!reset)
		begin
			want = expected.exists(cycle) ? expected[cycle] : writeback_t'(0);
			check_field("ex_o.valid", 128'(ex.valid), 128'(want.valid));
			if (want.valid)
			begin
				check_field("ex_o.value", 128'(ex.value), 128'(want.value));
				check_field("ex_o.mask", 128'(ex.mask), 128'(want.mask));
				check_field("ex_o.pc", 128'(ex.pc), 128'(want.pc));
				check_field("ex_o.strand/dest/wb",
					128'({ex.strand, ex.dest, ex.scalar_wb, ex.vector_wb}),
					128'({want.strand, want.dest, want.scalar_wb, want.vector_wb}));
			end
			check_field("rollback_o", 128'(rollback), 128'(exp_rollback));
			if (exp_rollback)
				check_field("rollback_pc_o", 128'(rollback_pc), 128'(exp_rollback_pc));
		end
	end

	initial
	begin
		issue_t ins;
		void'($urandom(32'h1ee3));
		stages = u_execute_stage.MUL_STAGES;
		issue = '0;
		regs = '0;
		commit = '0;
		squash = '0;
		commit_plan = '0;
		exp_rollback = 1'b0;
		exp_rollback_pc = '0;
		for (int r = 0; r < 32; r++)
		begin
			srf[r] = $urandom;
			vrf[r] = {$urandom, $urandom, $urandom, $urandom};
		end
		// Known values for the branch conditions
		srf[0] = '0;
		srf[3] = '1;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		// Mixed ops with random commit traffic
		for (int n = 0; n < 200; n++)
		begin
			commit_plan = random_commit();
			step(random_issue(alu_op_e'($urandom_range(0, 8))), -1);
		end

		// Back-to-back multiplies, then short ops that must wait their turn
		repeat (4) step(random_issue(OP_MUL), -1);
		repeat (6) step(random_issue(OP_ADD), -1);
		repeat (stages + 2) step('0, -1);

		for (int b = 1; b <= 5; b++)
			for (int p = 0; p < 2; p++)
				for (int s = 0; s < 2; s++)
				begin
					ins = random_issue(OP_ADD);
					ins.branch = branch_e'(b);
					ins.predicted_taken = 1'(p);
					ins.op1_is_vector = 1'b0;
					ins.sel_s1 = s ? 5'd3 : 5'd0;
					ins.scalar_wb = 1'b0;
					ins.vector_wb = 1'b0;
					step(ins, -1);
				end
		// Second write sits in ex_o while the PC read must still win
		for (int p = 0; p < 2; p++)
		begin
			ins = random_issue(OP_ADD);
			ins.predicted_taken = 1'(p);
			ins.op1_is_vector = 1'b0;
			ins.sel_s1 = REG_PC;
			ins.scalar_wb = 1'b1;
			ins.dest = REG_PC;
			step(ins, -1);
		end

		// Squash one multiply per sub-stage with live neighbours around it
		for (int k = 0; k < 4; k++)
		begin
			step(random_issue(OP_SUB), -1);
			step(random_issue(OP_MUL), k);
			step(random_issue(OP_MUL), -1);
			// Mispredicted branch killed at issue
			ins = random_issue(OP_OR);
			ins.branch = BR_ALWAYS;
			step(ins, 0);
			step(random_issue(OP_XOR), -1);
			repeat (stages + 2) step('0, -1);
		end

		repeat (stages + 4) step('0, -1);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: compile.f
source/exec_pkg.sv
source/operand_bypass.sv
source/lane_alu.sv
source/branch_resolve.sv
source/long_latency_pipe.sv
source/result_merge.sv
source/execute_stage.sv
tests/tb_clock.sv
tests/execute_stage_chk.sv
tests/execute_stage_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = execute_stage_tb
FILELIST = compile.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
